// File: logic/sd_dma_pkg.sv
//////////////////////////////////////////////////
// shared widths and types for the adma datapath
// register offsets, descriptor fields, fsm states
//////////////////////////////////////////////////

package sd_dma_pkg;

   // basic data types
   typedef logic [31:0] addr_t;       // byte address
   typedef logic [31:0] word_t;       // ram / fifo data word
   typedef logic [7:0]  ram_index_t;  // word index into system ram
   typedef logic [15:0] count_t;      // transferred word count

   localparam int RAM_WORDS  = 256;
   localparam int FIFO_DEPTH = 8;
   localparam int FIFO_PTR_W = 3;     // log2 of fifo depth

   typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
   typedef logic [FIFO_PTR_W:0]   fifo_cnt_t;  // one extra bit for full

   //////////////////////////////////////////////////
   // register map
   //////////////////////////////////////////////////
   localparam addr_t REG_CTRL   = 32'h0000_0000;
   localparam addr_t REG_BASE   = 32'h0000_0004;
   localparam addr_t REG_STATUS = 32'h0000_0008;
   localparam addr_t REG_COUNT  = 32'h0000_000C;

   //////////////////////////////////////////////////
   // descriptor word 0 layout
   //////////////////////////////////////////////////
   localparam int ATTR_VALID  = 0;
   localparam int ATTR_END    = 1;
   localparam int ACT_LSB     = 4;    // 2 bit action field
   localparam int LEN_LSB     = 16;   // 16 bit byte length
   localparam int DESC_STRIDE = 8;    // bytes per descriptor

   localparam logic [1:0] ACT_NOP  = 2'b00;
   localparam logic [1:0] ACT_TRAN = 2'b10;
   localparam logic [1:0] ACT_LINK = 2'b11;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_FETCH0,   // read word 0
      ST_FETCH1,   // read word 1, latch word 0
      ST_DECODE,
      ST_DATA,
      ST_DONE,
      ST_ERROR
   } engine_state_t;

endpackage

// File: logic/system_ram.sv
//////////////////////////////////////////////////
// dual port system ram
// host read/write port plus engine read port
// byte addressed, word aligned, registered reads
//////////////////////////////////////////////////
`timescale 1ns/1ps

module system_ram (
   input  logic               CLK,
   // host side
   input  logic               host_en,
   input  logic               host_we,
   input  sd_dma_pkg::addr_t  host_addr,
   input  sd_dma_pkg::word_t  host_wdata,
   output sd_dma_pkg::word_t  host_rdata,
   // engine side, read only
   input  logic               eng_rd_en,
   input  sd_dma_pkg::addr_t  eng_addr,
   output sd_dma_pkg::word_t  eng_rdata
);

   sd_dma_pkg::word_t mem [sd_dma_pkg::RAM_WORDS];

   sd_dma_pkg::ram_index_t host_idx;
   sd_dma_pkg::ram_index_t eng_idx;
   logic                   host_ok;
   logic                   eng_ok;

   // byte address to word index, upper bits wrap
   assign host_idx = sd_dma_pkg::ram_index_t'(host_addr >> 2);
   assign eng_idx  = sd_dma_pkg::ram_index_t'(eng_addr >> 2);

   // misaligned accesses dropped
   assign host_ok = host_en && (host_addr[1:0] == 2'b00);
   assign eng_ok  = eng_rd_en && (eng_addr[1:0] == 2'b00);

   // cleared contents at power up
   initial begin
      for (int i = 0; i < sd_dma_pkg::RAM_WORDS; i++) begin
         mem[i] = '0;
      end
   end

   // host port, read first on a write cycle
   always_ff @(posedge CLK) begin
      if (host_ok) begin
         if (host_we) begin
            mem[host_idx] <= host_wdata;
         end
         host_rdata <= mem[host_idx];
      end
   end

   // engine port
   always_ff @(posedge CLK) begin
      if (eng_ok) begin
         eng_rdata <= mem[eng_idx];  // valid the cycle after eng_rd_en
      end
   end

endmodule

// File: logic/dma_regs.sv
//////////////////////////////////////////////////
// axi4-lite register slave for the adma engine
// ctrl / base / status / count registers
// sticky done and error flags
//////////////////////////////////////////////////
`timescale 1ns/1ps

module dma_regs (
   input  logic                CLK,
   input  logic                rst_n,
   // write address
   input  sd_dma_pkg::addr_t   awaddr,
   input  logic                awvalid,
   output logic                awready,
   // write data
   input  sd_dma_pkg::word_t   wdata,
   input  logic                wvalid,
   output logic                wready,
   // write response
   output logic [1:0]          bresp,
   output logic                bvalid,
   input  logic                bready,
   // read address
   input  sd_dma_pkg::addr_t   araddr,
   input  logic                arvalid,
   output logic                arready,
   // read data
   output sd_dma_pkg::word_t   rdata,
   output logic [1:0]          rresp,
   output logic                rvalid,
   input  logic                rready,
   // engine side
   output logic                start,
   output sd_dma_pkg::addr_t   desc_base,
   input  logic                busy,
   input  logic                done_pulse,
   input  logic                error_pulse,
   input  sd_dma_pkg::count_t  word_count
);

   logic              wr_go;      // write accepted this cycle
   logic              rd_go;      // read address accepted
   logic              done_bit;
   logic              error_bit;
   sd_dma_pkg::word_t rd_mux;

   assign wr_go   = awvalid && wvalid && !bvalid;
   assign awready = wr_go;        // both raised together
   assign wready  = wr_go;
   assign arready = !rvalid;      // one read outstanding
   assign rd_go   = arvalid && arready;
   assign bresp   = 2'b00;        // always okay
   assign rresp   = 2'b00;

   //////////////////////////////////////////////////
   // write path
   //////////////////////////////////////////////////
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         bvalid    <= 1'b0;
         start     <= 1'b0;
         desc_base <= '0;
      end else begin
         // kick only when the engine is idle
         start <= wr_go && (awaddr == sd_dma_pkg::REG_CTRL) && wdata[0] && !busy;
         if (wr_go) begin
            bvalid <= 1'b1;
            if (awaddr == sd_dma_pkg::REG_BASE) begin
               desc_base <= wdata;
            end
         end else if (bready) begin
            bvalid <= 1'b0;       // response taken
         end
      end
   end

   // sticky flags, new start wipes them
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         done_bit  <= 1'b0;
         error_bit <= 1'b0;
      end else if (start) begin
         done_bit  <= 1'b0;
         error_bit <= 1'b0;
      end else begin
         if (done_pulse)  done_bit  <= 1'b1;
         if (error_pulse) error_bit <= 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // read path
   //////////////////////////////////////////////////
   always_comb begin
      case (araddr)
         sd_dma_pkg::REG_BASE:   rd_mux = desc_base;
         sd_dma_pkg::REG_STATUS: rd_mux = {29'b0, error_bit, done_bit, busy};
         sd_dma_pkg::REG_COUNT:  rd_mux = {16'b0, word_count};
         default:                rd_mux = '0;  // ctrl self clears, rest unmapped
      endcase
   end

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         rvalid <= 1'b0;
      end else if (rd_go) begin
         rvalid <= 1'b1;
      end else if (rready) begin
         rvalid <= 1'b0;
      end
   end

   always_ff @(posedge CLK) begin
      if (rd_go) begin
         rdata <= rd_mux;         // held until rready
      end
   end

endmodule

// File: logic/adma_engine.sv
//////////////////////////////////////////////////
// adma descriptor engine
// fetch, decode, link and tran streaming to fifo
//////////////////////////////////////////////////
`timescale 1ns/1ps

module adma_engine (
   input  logic                CLK,
   input  logic                rst_n,
   input  logic                start,
   input  sd_dma_pkg::addr_t   desc_base,
   // status back to registers
   output logic                busy,
   output logic                done_pulse,
   output logic                error_pulse,
   output sd_dma_pkg::count_t  word_count,
   // ram engine port
   output logic                eng_rd_en,
   output sd_dma_pkg::addr_t   eng_addr,
   input  sd_dma_pkg::word_t   eng_rdata,
   // fifo push side
   output logic                push,
   output sd_dma_pkg::word_t   push_data,
   input  logic                full,
   input  logic                almost_full
);

   sd_dma_pkg::engine_state_t state;

   sd_dma_pkg::addr_t  desc_addr;    // current descriptor
   sd_dma_pkg::addr_t  data_addr;    // next data word to read
   sd_dma_pkg::word_t  desc_w0;      // latched attribute / length word
   sd_dma_pkg::count_t reads_left;   // data reads still to issue
   logic               rd_inflight;  // data read issued last cycle

   logic               d_valid;
   logic               d_end;
   logic [1:0]         d_act;
   sd_dma_pkg::count_t d_words;      // length in words
   logic               rd_go;

   // word 0 fields
   assign d_valid = desc_w0[sd_dma_pkg::ATTR_VALID];
   assign d_end   = desc_w0[sd_dma_pkg::ATTR_END];
   assign d_act   = desc_w0[sd_dma_pkg::ACT_LSB +: 2];
   assign d_words = desc_w0[sd_dma_pkg::LEN_LSB +: 16] >> 2;  // low len bits ignored

   // room for the word in flight plus this one
   assign rd_go = (state == sd_dma_pkg::ST_DATA) && (reads_left != '0) &&
                  (rd_inflight ? !almost_full : !full);

   assign push        = rd_inflight;  // ram data lands one cycle later
   assign push_data   = eng_rdata;
   assign busy        = (state != sd_dma_pkg::ST_IDLE);
   assign done_pulse  = (state == sd_dma_pkg::ST_DONE);
   assign error_pulse = (state == sd_dma_pkg::ST_ERROR);

   //////////////////////////////////////////////////
   // ram port mux
   //////////////////////////////////////////////////
   always_comb begin
      eng_rd_en = 1'b0;
      eng_addr  = desc_addr;
      case (state)
         sd_dma_pkg::ST_FETCH0: begin
            eng_rd_en = 1'b1;
         end
         sd_dma_pkg::ST_FETCH1: begin
            eng_rd_en = 1'b1;
            eng_addr  = desc_addr + 32'd4;  // word 1
         end
         sd_dma_pkg::ST_DATA: begin
            eng_rd_en = rd_go;
            eng_addr  = data_addr;
         end
         default: ;
      endcase
   end

   //////////////////////////////////////////////////
   // descriptor state machine
   //////////////////////////////////////////////////
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         state       <= sd_dma_pkg::ST_IDLE;
         rd_inflight <= 1'b0;
         reads_left  <= '0;
         word_count  <= '0;
      end else begin
         rd_inflight <= rd_go;
         if (push) begin
            word_count <= word_count + 16'd1;
         end
         case (state)
            sd_dma_pkg::ST_IDLE: begin
               if (start) begin
                  desc_addr  <= desc_base;
                  word_count <= '0;
                  state      <= sd_dma_pkg::ST_FETCH0;
               end
            end
            sd_dma_pkg::ST_FETCH0: begin
               state <= sd_dma_pkg::ST_FETCH1;
            end
            sd_dma_pkg::ST_FETCH1: begin
               desc_w0 <= eng_rdata;        // word 0 back now
               state   <= sd_dma_pkg::ST_DECODE;
            end
            sd_dma_pkg::ST_DECODE: begin     // eng_rdata holds word 1 here
               if (!d_valid) begin
                  state <= sd_dma_pkg::ST_ERROR;
               end else if (d_act == sd_dma_pkg::ACT_LINK) begin
                  desc_addr <= eng_rdata;    // jump, end bit not honoured
                  state     <= sd_dma_pkg::ST_FETCH0;
               end else if (d_act == sd_dma_pkg::ACT_TRAN && d_words != '0) begin
                  data_addr  <= eng_rdata;
                  reads_left <= d_words;
                  state      <= sd_dma_pkg::ST_DATA;
               end else if (d_end) begin     // nop, empty tran
                  state <= sd_dma_pkg::ST_DONE;
               end else begin
                  desc_addr <= desc_addr + 32'(sd_dma_pkg::DESC_STRIDE);
                  state     <= sd_dma_pkg::ST_FETCH0;
               end
            end
            sd_dma_pkg::ST_DATA: begin
               if (rd_go) begin
                  data_addr  <= data_addr + 32'd4;
                  reads_left <= reads_left - 16'd1;
               end else if (reads_left == '0) begin
                  // last word pushes this cycle at the latest
                  if (d_end) begin
                     state <= sd_dma_pkg::ST_DONE;
                  end else begin
                     desc_addr <= desc_addr + 32'(sd_dma_pkg::DESC_STRIDE);
                     state     <= sd_dma_pkg::ST_FETCH0;
                  end
               end
            end
            sd_dma_pkg::ST_DONE: begin
               state <= sd_dma_pkg::ST_IDLE;
            end
            sd_dma_pkg::ST_ERROR: begin
               state <= sd_dma_pkg::ST_IDLE;
            end
            default: begin
               state <= sd_dma_pkg::ST_IDLE;
            end
         endcase
      end
   end

endmodule

// File: logic/data_fifo.sv
//////////////////////////////////////////////////
// synchronous data fifo, engine to card port
//////////////////////////////////////////////////
`timescale 1ns/1ps

module data_fifo (
   input  logic               CLK,
   input  logic               rst_n,
   input  logic               push,
   input  sd_dma_pkg::word_t  push_data,
   output logic               full,
   output logic               almost_full,
   output sd_dma_pkg::word_t  card_data,
   output logic               card_valid,
   input  logic               card_ready
);

   sd_dma_pkg::word_t     mem [sd_dma_pkg::FIFO_DEPTH];
   sd_dma_pkg::fifo_ptr_t wr_ptr;
   sd_dma_pkg::fifo_ptr_t rd_ptr;
   sd_dma_pkg::fifo_cnt_t count;   // occupancy
   logic                  do_push;
   logic                  do_pop;

   assign do_push = push && !full;         // dropped when full
   assign do_pop  = card_valid && card_ready;

   assign full        = (count == sd_dma_pkg::fifo_cnt_t'(sd_dma_pkg::FIFO_DEPTH));
   assign almost_full = (count >= sd_dma_pkg::fifo_cnt_t'(sd_dma_pkg::FIFO_DEPTH - 1));
   assign card_valid  = (count != '0);
   assign card_data   = mem[rd_ptr];       // head word

   // storage
   always_ff @(posedge CLK) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // pointers wrap naturally at depth 8
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;        // both or neither
         endcase
      end
   end

endmodule

// File: logic/sd_dma_top.sv
//////////////////////////////////////////////////
// sd host dma top
// registers, adma engine, system ram, data fifo
//////////////////////////////////////////////////
`timescale 1ns/1ps

module sd_dma_top (
   input  logic               CLK,
   input  logic               rst_n,
   // axi4-lite slave
   input  sd_dma_pkg::addr_t  awaddr,
   input  logic               awvalid,
   output logic               awready,
   input  sd_dma_pkg::word_t  wdata,
   input  logic               wvalid,
   output logic               wready,
   output logic [1:0]         bresp,
   output logic               bvalid,
   input  logic               bready,
   input  sd_dma_pkg::addr_t  araddr,
   input  logic               arvalid,
   output logic               arready,
   output sd_dma_pkg::word_t  rdata,
   output logic [1:0]         rresp,
   output logic               rvalid,
   input  logic               rready,
   // host memory access
   input  logic               host_en,
   input  logic               host_we,
   input  sd_dma_pkg::addr_t  host_addr,
   input  sd_dma_pkg::word_t  host_wdata,
   output sd_dma_pkg::word_t  host_rdata,
   // card data port
   output sd_dma_pkg::word_t  card_data,
   output logic               card_valid,
   input  logic               card_ready
);

   // regs <-> engine
   logic               start;
   sd_dma_pkg::addr_t  desc_base;
   logic               busy;
   logic               done_pulse;
   logic               error_pulse;
   sd_dma_pkg::count_t word_count;

   // engine <-> ram
   logic               eng_rd_en;
   sd_dma_pkg::addr_t  eng_addr;
   sd_dma_pkg::word_t  eng_rdata;

   // engine <-> fifo
   logic               push;
   sd_dma_pkg::word_t  push_data;
   logic               full;
   logic               almost_full;

   dma_regs dma_regs_inst (.*);

   adma_engine adma_engine_inst (.*);

   system_ram system_ram_inst (.*);

   data_fifo data_fifo_inst (.*);

endmodule

// File: verification/sd_dma_properties.sv
//////////////////////////////////////////////////
// bound assertions for the sd dma top
// axi response hold, card port stall, fifo overflow
//////////////////////////////////////////////////
`timescale 1ns/1ps

module sd_dma_properties (
   input logic               CLK,
   input logic               rst_n,
   input logic               bvalid,
   input logic               bready,
   input logic               rvalid,
   input logic               rready,
   input sd_dma_pkg::word_t  card_data,
   input logic               card_valid,
   input logic               card_ready,
   input logic               push,    // engine to fifo
   input logic               full
);

   // write response held until taken
   bvalid_hold: assert property (@(posedge CLK) disable iff (!rst_n)
      bvalid && !bready |=> bvalid)
      else $error("bvalid dropped before bready");

   // read data held until taken
   rvalid_hold: assert property (@(posedge CLK) disable iff (!rst_n)
      rvalid && !rready |=> rvalid)
      else $error("rvalid dropped before rready");

   // stalled head word must not move
   card_stall: assert property (@(posedge CLK) disable iff (!rst_n)
      card_valid && !card_ready |=> card_valid && $stable(card_data))
      else $error("card word changed while stalled");

   // engine must respect full
   no_overflow: assert property (@(posedge CLK) disable iff (!rst_n)
      !(push && full))
      else $error("push while fifo full");

endmodule

// File: verification/sd_dma_tb.sv
//////////////////////////////////////////////////
// testbench for the sd dma top
// lcg stimulus, ram mirror, descriptor walk model
// register, host port and transfer checks
//////////////////////////////////////////////////
`timescale 1ns/1ps

module sd_dma_tb;

   localparam int          MAX_CYCLES = 20000;  // longest test is ~600 cycles
   localparam logic [31:0] SEED       = 32'h9fa2;

   logic               CLK;
   logic               rst_n;
   sd_dma_pkg::addr_t  awaddr;
   logic               awvalid;
   logic               awready;
   sd_dma_pkg::word_t  wdata;
   logic               wvalid;
   logic               wready;
   logic [1:0]         bresp;
   logic               bvalid;
   logic               bready;
   sd_dma_pkg::addr_t  araddr;
   logic               arvalid;
   logic               arready;
   sd_dma_pkg::word_t  rdata;
   logic [1:0]         rresp;
   logic               rvalid;
   logic               rready;
   logic               host_en;
   logic               host_we;
   sd_dma_pkg::addr_t  host_addr;
   sd_dma_pkg::word_t  host_wdata;
   sd_dma_pkg::word_t  host_rdata;
   sd_dma_pkg::word_t  card_data;
   logic               card_valid;
   logic               card_ready;

   sd_dma_pkg::word_t  mirror [sd_dma_pkg::RAM_WORDS];  // expected ram content
   sd_dma_pkg::word_t  got_q [$];     // everything seen on the card port
   sd_dma_pkg::word_t  exp_q [$];     // model stream for the current test
   int                 stream_mark;   // got_q size at test start
   logic               throttle;      // random card_ready when set
   logic [31:0]        rand_state;
   logic [31:0]        ready_state;
   int                 cycle_count;
   int                 errors;
   int                 errors_mark;
   int                 tests_run;
   int                 tests_failed;

   sd_dma_top sd_dma_top_inst (.*);

   bind sd_dma_top sd_dma_properties sd_dma_properties_inst (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .bvalid     (bvalid),
      .bready     (bready),
      .rvalid     (rvalid),
      .rready     (rready),
      .card_data  (card_data),
      .card_valid (card_valid),
      .card_ready (card_ready),
      .push       (push),
      .full       (full)
   );

   initial begin
      CLK = 1'b0;
      forever #10 CLK = ~CLK;  // 20 ns period
   end

   // run limit
   initial begin
      cycle_count = 0;
      while (cycle_count < MAX_CYCLES) begin
         @(posedge CLK);
         cycle_count++;
      end
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

   //////////////////////////////////////////////////
   // card side sink
   //////////////////////////////////////////////////
   initial begin
      card_ready  = 1'b0;
      ready_state = ~SEED;    // own stream, keeps data lcg order fixed
      forever begin
         @(negedge CLK);
         ready_state = lcg_step(ready_state);
         card_ready  = throttle ? (ready_state[17:16] == 2'b00) : 1'b1;  // ~25% when throttled
         if (card_ready && card_valid) begin
            got_q.push_back(card_data);  // moves on the next rising edge
         end
      end
   end

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic sd_dma_pkg::word_t next_rand();
      rand_state = lcg_step(rand_state);
      return rand_state;
   endfunction

   task automatic note_mismatch(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
      errors++;
      $display("FAIL %0t ns %s got %08h expected %08h", $time, what, got, exp);
   endtask

   task automatic close_test(input string name);
      tests_run++;
      if (errors == errors_mark) begin
         $display("test %0d %s ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s had %0d errors", tests_run, name, errors - errors_mark);
      end
      errors_mark = errors;
   endtask

   //////////////////////////////////////////////////
   // bus access tasks
   //////////////////////////////////////////////////
   task automatic write_reg(input sd_dma_pkg::addr_t addr, input sd_dma_pkg::word_t data);
      @(negedge CLK);
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      @(posedge CLK);
      if (!(awready && wready)) note_mismatch("awready/wready on accept", {awready, wready}, 2'b11);
      @(negedge CLK);
      while (!bvalid) @(negedge CLK);  // bvalid rises on accept
      if (awready) note_mismatch("awready with response pending", awready, 1'b0);
      if (bresp != 2'b00) note_mismatch("bresp", bresp, 2'b00);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b1;
      @(negedge CLK);
      bready  = 1'b0;
   endtask

   task automatic read_reg(input sd_dma_pkg::addr_t addr, output sd_dma_pkg::word_t data);
      @(negedge CLK);
      araddr  = addr;
      arvalid = 1'b1;
      @(posedge CLK);
      if (!arready) note_mismatch("arready with no read pending", arready, 1'b1);
      @(negedge CLK);
      while (!rvalid) @(negedge CLK);
      if (arready) note_mismatch("arready with read data pending", arready, 1'b0);
      if (rresp != 2'b00) note_mismatch("rresp", rresp, 2'b00);
      arvalid = 1'b0;
      data    = rdata;
      rready  = 1'b1;
      @(negedge CLK);
      rready  = 1'b0;
   endtask

   task automatic poke_ram(input sd_dma_pkg::addr_t addr, input sd_dma_pkg::word_t data);
      @(negedge CLK);
      host_en    = 1'b1;
      host_we    = 1'b1;
      host_addr  = addr;
      host_wdata = data;
      @(negedge CLK);
      host_en    = 1'b0;
      host_we    = 1'b0;
      if (addr[1:0] == 2'b00) begin
         mirror[addr[9:2]] = data;  // misaligned writes are dropped
      end
   endtask

   task automatic peek_ram(input sd_dma_pkg::addr_t addr, output sd_dma_pkg::word_t data);
      @(negedge CLK);
      host_en   = 1'b1;
      host_we   = 1'b0;
      host_addr = addr;
      @(negedge CLK);
      host_en   = 1'b0;
      data      = host_rdata;  // registered one cycle later
   endtask

   task automatic fill_words(input sd_dma_pkg::addr_t addr, input int n);
      int i;
      for (i = 0; i < n; i++) begin
         poke_ram(addr + 32'(i * 4), next_rand());
      end
   endtask

   function automatic sd_dma_pkg::word_t make_w0(input logic [1:0] act, input logic last,
                                                 input int len_bytes);
      sd_dma_pkg::word_t w;
      w = '0;
      w[sd_dma_pkg::ATTR_VALID]     = 1'b1;
      w[sd_dma_pkg::ATTR_END]       = last;
      w[sd_dma_pkg::ACT_LSB +: 2]   = act;
      w[31:16]                      = 16'(len_bytes);
      return w;
   endfunction

   task automatic put_desc(input sd_dma_pkg::addr_t addr, input sd_dma_pkg::word_t w0,
                           input sd_dma_pkg::word_t w1);
      poke_ram(addr, w0);
      poke_ram(addr + 32'd4, w1);
   endtask

   //////////////////////////////////////////////////
   // descriptor model and transfer checks
   //////////////////////////////////////////////////
   task automatic predict_chain(input sd_dma_pkg::addr_t base, output logic done_exp,
                                output logic err_exp);
      sd_dma_pkg::addr_t a;
      sd_dma_pkg::word_t w0;
      sd_dma_pkg::word_t w1;
      logic [7:0]        idx;
      int                steps;
      int                i;
      exp_q.delete();
      done_exp = 1'b0;
      err_exp  = 1'b0;
      a        = base;
      for (steps = 0; steps < 32 && !done_exp && !err_exp; steps++) begin
         idx = a[9:2];
         w0  = mirror[idx];
         idx = a[9:2] + 8'd1;
         w1  = mirror[idx];
         if (!w0[0]) begin
            err_exp = 1'b1;            // valid clear
         end else if (w0[5:4] == sd_dma_pkg::ACT_LINK) begin
            a = w1;                    // jump
         end else begin
            if (w0[5:4] == sd_dma_pkg::ACT_TRAN) begin
               for (i = 0; i < int'(w0[31:18]); i++) begin  // length / 4
                  idx = w1[9:2] + 8'(i);
                  exp_q.push_back(mirror[idx]);
               end
            end
            if (w0[1]) begin
               done_exp = 1'b1;
            end else begin
               a = a + 32'd8;
            end
         end
      end
   endtask

   task automatic run_transfer(input sd_dma_pkg::addr_t base, input logic bp,
                               output sd_dma_pkg::word_t status,
                               output sd_dma_pkg::word_t count);
      throttle    = bp;
      stream_mark = got_q.size();
      write_reg(sd_dma_pkg::REG_BASE, base);
      write_reg(sd_dma_pkg::REG_CTRL, 32'h1);
      status = 32'h1;
      while (status[0]) begin
         read_reg(sd_dma_pkg::REG_STATUS, status);  // poll busy
      end
      while (card_valid) @(negedge CLK);  // let the fifo drain
      read_reg(sd_dma_pkg::REG_COUNT, count);
   endtask

   task automatic check_outcome(input string what, input sd_dma_pkg::word_t status,
                                input sd_dma_pkg::word_t count, input logic done_exp,
                                input logic err_exp);
      sd_dma_pkg::word_t want;
      int                got_n;
      int                i;
      want  = {29'b0, err_exp, done_exp, 1'b0};  // busy clear at the end
      got_n = got_q.size() - stream_mark;
      if (status != want) note_mismatch({what, " status"}, status, want);
      if (count != 32'(exp_q.size())) note_mismatch({what, " count"}, count, exp_q.size());
      if (got_n != exp_q.size()) note_mismatch({what, " words seen"}, got_n, exp_q.size());
      for (i = 0; i < got_n && i < exp_q.size(); i++) begin
         if (got_q[stream_mark + i] != exp_q[i]) begin
            note_mismatch($sformatf("%s word %0d", what, i), got_q[stream_mark + i], exp_q[i]);
         end
      end
   endtask

   task automatic run_and_check(input string name, input sd_dma_pkg::addr_t base,
                                input logic bp);
      sd_dma_pkg::word_t status;
      sd_dma_pkg::word_t count;
      logic              done_exp;
      logic              err_exp;
      predict_chain(base, done_exp, err_exp);
      run_transfer(base, bp, status, count);
      check_outcome(name, status, count, done_exp, err_exp);
      close_test(name);
   endtask

   //////////////////////////////////////////////////
   // tests
   //////////////////////////////////////////////////
   task automatic probe_registers();
      sd_dma_pkg::word_t v;
      sd_dma_pkg::word_t base_val;
      read_reg(sd_dma_pkg::REG_STATUS, v);
      if (v != 32'h0) note_mismatch("status after reset", v, 32'h0);
      base_val = next_rand();
      write_reg(sd_dma_pkg::REG_BASE, base_val);
      read_reg(sd_dma_pkg::REG_BASE, v);
      if (v != base_val) note_mismatch("base readback", v, base_val);
      read_reg(32'h10, v);  // unmapped
      if (v != 32'h0) note_mismatch("offset 0x10", v, 32'h0);
      read_reg(32'h7c, v);
      if (v != 32'h0) note_mismatch("offset 0x7c", v, 32'h0);
      close_test("register access");
   endtask

   task automatic exercise_host_port();
      sd_dma_pkg::addr_t a;
      sd_dma_pkg::word_t r;
      sd_dma_pkg::word_t v;
      int                i;
      for (i = 0; i < 12; i++) begin
         r = next_rand();
         a = {22'b0, r[15:8], 2'b00};   // any word in the ram
         poke_ram(a, next_rand());
         peek_ram(a, v);
         if (v != mirror[a[9:2]]) note_mismatch($sformatf("host word %03h", a), v, mirror[a[9:2]]);
      end
      poke_ram(32'h104, 32'h1234_5678);
      poke_ram(32'h106, 32'hdead_beef);  // misaligned, must not land
      peek_ram(32'h104, v);
      if (v != mirror[8'h41]) note_mismatch("misaligned write", v, mirror[8'h41]);
      close_test("host port");
   endtask

   task automatic single_tran_transfer();
      sd_dma_pkg::word_t r;
      int                n;
      r = next_rand();
      n = 4 + int'(r[12:8]);
      fill_words(32'h100, n);
      put_desc(32'h000, make_w0(sd_dma_pkg::ACT_TRAN, 1'b1, n * 4 + int'(r[1:0])), 32'h100);
      run_and_check("single tran", 32'h000, 1'b0);
   endtask

   task automatic walk_descriptor_chain();
      sd_dma_pkg::word_t r;
      int                n1;
      int                n2;
      r  = next_rand();
      n1 = 2 + int'(r[10:8]);
      n2 = 3 + int'(r[14:12]);
      fill_words(32'h200, n1);
      fill_words(32'h280, n2);
      put_desc(32'h040, make_w0(sd_dma_pkg::ACT_NOP, 1'b0, 0), 32'h0);
      put_desc(32'h048, make_w0(sd_dma_pkg::ACT_TRAN, 1'b0, n1 * 4), 32'h200);
      put_desc(32'h050, make_w0(sd_dma_pkg::ACT_LINK, 1'b0, 0), 32'h080);
      put_desc(32'h080, make_w0(sd_dma_pkg::ACT_TRAN, 1'b1, n2 * 4 + 3), 32'h280);
      run_and_check("descriptor chain", 32'h040, 1'b0);
   endtask

   task automatic stop_on_invalid();
      sd_dma_pkg::word_t r;
      int                n;
      r = next_rand();
      n = 2 + int'(r[11:8]);
      fill_words(32'h300, n);
      put_desc(32'h0a0, make_w0(sd_dma_pkg::ACT_TRAN, 1'b0, n * 4), 32'h300);
      put_desc(32'h0a8, 32'h0000_0020, 32'h0);  // tran action, valid clear
      run_and_check("invalid descriptor", 32'h0a0, 1'b0);
   endtask

   task automatic throttled_transfer();
      sd_dma_pkg::word_t r;
      int                n;
      r = next_rand();
      n = 96 + int'(r[11:8]);  // long enough to fill the fifo often
      fill_words(32'h100, n);
      put_desc(32'h0c0, make_w0(sd_dma_pkg::ACT_TRAN, 1'b1, n * 4), 32'h100);
      run_and_check("back-pressure", 32'h0c0, 1'b1);
   endtask

   initial begin
      rst_n        = 1'b0;
      awaddr       = '0;
      awvalid      = 1'b0;
      wdata        = '0;
      wvalid       = 1'b0;
      bready       = 1'b0;
      araddr       = '0;
      arvalid      = 1'b0;
      rready       = 1'b0;
      host_en      = 1'b0;
      host_we      = 1'b0;
      host_addr    = '0;
      host_wdata   = '0;
      throttle     = 1'b0;
      rand_state   = SEED;
      stream_mark  = 0;
      errors       = 0;
      errors_mark  = 0;
      tests_run    = 0;
      tests_failed = 0;
      for (int i = 0; i < sd_dma_pkg::RAM_WORDS; i++) begin
         mirror[i] = '0;  // ram starts cleared
      end
      repeat (8) @(negedge CLK);
      rst_n = 1'b1;

      probe_registers();
      exercise_host_port();
      single_tran_transfer();
      walk_descriptor_chain();
      stop_on_invalid();
      throttled_transfer();

      $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: filelist.f
logic/sd_dma_pkg.sv
logic/system_ram.sv
logic/dma_regs.sv
logic/adma_engine.sv
logic/data_fifo.sv
logic/sd_dma_top.sv
verification/sd_dma_properties.sv
verification/sd_dma_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the sd dma testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module sd_dma_tb \
   -f filelist.f \
   -o sd_dma_sim

# the run counts as passed only when the pass line shows up
./obj_dir/sd_dma_sim | tee /dev/stderr | grep -x "TEST PASSED" > /dev/null
